/* sources.f */
+incdir+.
cache_pkg.sv
bus_pkg.sv
next_line_prefetcher.sv
line_cache.sv
mem_arbiter.sv
main_memory.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_fetch_subsystem -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "sim passed" \
    && echo "run ok" \
    || { echo "run failed"; exit 1; }

/* tb_fetch_subsystem.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch_subsystem;

    localparam int LINE_BYTES = `LINE_BITS / 8;
    localparam int SPAN_BITS  = $clog2(`MEM_LINES * LINE_BYTES); // bytes covered by memory
    localparam int TIMEOUT    = 200;
    localparam int N_FETCH    = 24;
    localparam int N_MIXED    = 40;

    // separate address regions keep each test's lines out of the caches
    localparam cache_pkg::addr_t PF_BASE = 32'h0000_4000;
    localparam cache_pkg::addr_t BR_BASE = 32'h0000_8000;

    logic                clk;
    logic                rst;
    logic                i_read;
    cache_pkg::addr_t    i_addr;
    logic                branch_taken;
    cache_pkg::line_t    i_rdata;
    logic                i_resp;
    logic                d_read;
    cache_pkg::addr_t    d_addr;
    cache_pkg::line_t    d_rdata;
    logic                d_resp;
    logic                load_we;
    bus_pkg::mem_index_t load_index;
    cache_pkg::line_t    load_data;

    cache_pkg::line_t model [`MEM_LINES]; // reference copy of main memory
    cache_pkg::addr_t d_list [N_MIXED];
    cache_pkg::addr_t i_list [N_MIXED];
    logic [15:0]      lfsr;
    int               errors;
    int               err_mark;
    int               tests_ok;
    int               tests_bad;

    cache_pkg::addr_t a;
    cache_pkg::line_t got;
    cache_pkg::line_t d_got;
    cache_pkg::line_t i_got;
    int               cyc;

    fetch_subsystem u_fetch_subsystem (
        .clk(clk), .rst(rst),
        .i_read(i_read), .i_addr(i_addr), .branch_taken(branch_taken),
        .i_rdata(i_rdata), .i_resp(i_resp),
        .d_read(d_read), .d_addr(d_addr), .d_rdata(d_rdata), .d_resp(d_resp),
        .load_we(load_we), .load_index(load_index), .load_data(load_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16-bit galois lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [`LINE_BITS-1:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr); // one step per bit
            value = {value[`LINE_BITS-2:0], lfsr[0]};
        end
    endtask

    // any byte inside one memory-sized window above base
    task automatic random_addr(input cache_pkg::addr_t base, output cache_pkg::addr_t addr);
        logic [`LINE_BITS-1:0] r;
        random_bits(SPAN_BITS, r);
        addr = base + cache_pkg::addr_t'(r[SPAN_BITS-1:0]);
    endtask

    function automatic cache_pkg::line_t expected_line(input cache_pkg::addr_t addr);
        bus_pkg::mem_index_t idx;
        idx = bus_pkg::mem_index_t'(addr / LINE_BYTES); // memory wraps above its size
        return model[idx];
    endfunction

    // read held until i_resp and dropped one cycle later
    task automatic fetch(input cache_pkg::addr_t addr, input logic branch,
                         output cache_pkg::line_t data, output int cycles);
        bit done;
        done         = 1'b0;
        cycles       = 0;
        data         = '0;
        i_read       = 1'b1;
        i_addr       = addr;
        branch_taken = branch;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            branch_taken = 1'b0; // single-cycle pulse
            cycles++;
            if (i_resp) begin
                data = i_rdata;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("timeout: no i_resp within %0d cycles for fetch of %h", TIMEOUT, addr);
            errors++;
        end
        @(negedge clk);
        i_read = 1'b0;
    endtask

    task automatic data_read(input cache_pkg::addr_t addr, output cache_pkg::line_t data);
        bit done;
        int cycles;
        done   = 1'b0;
        cycles = 0;
        data   = '0;
        d_read = 1'b1;
        d_addr = addr;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (d_resp) begin
                data = d_rdata;
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("timeout: no d_resp within %0d cycles for load of %h", TIMEOUT, addr);
            errors++;
        end
        @(negedge clk);
        d_read = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - err_mark);
            tests_bad++;
        end
        err_mark = errors;
    endtask

    initial begin
        lfsr         = 16'd42930;
        errors       = 0;
        err_mark     = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        rst          = 1'b1;
        i_read       = 1'b0;
        i_addr       = '0;
        branch_taken = 1'b0;
        d_read       = 1'b0;
        d_addr       = '0;
        load_we      = 1'b0;
        load_index   = '0;
        load_data    = '0;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        // no read applied, so no resp may show up
        repeat (8) begin
            @(negedge clk);
            if (i_resp || d_resp) begin
                $display("error reset expected 00 actual %b%b", i_resp, d_resp);
                errors++;
            end
        end
        finish_test("reset");

        // random contents mirrored into the DUT over the backdoor
        for (int i = 0; i < `MEM_LINES; i++) begin
            random_bits(`LINE_BITS, model[i]);
            load_we    = 1'b1;
            load_index = bus_pkg::mem_index_t'(i);
            load_data  = model[i];
            @(negedge clk);
        end
        load_we = 1'b0;

        for (int n = 0; n < N_FETCH; n++) begin
            random_addr('0, a);
            fetch(a, 1'b0, got, cyc);
            if (got !== expected_line(a)) begin
                $display("error instr_read expected %h actual %h", expected_line(a), got);
                errors++;
            end
            fetch(a, 1'b0, got, cyc); // same line again, now a hit
            if (got !== expected_line(a)) begin
                $display("error instr_hit expected %h actual %h", expected_line(a), got);
                errors++;
            end
            if (cyc != 1) begin
                $display("error instr_hit expected 1 cycle actual %0d", cyc);
                errors++;
            end
        end
        finish_test("instr_read");

        random_addr(PF_BASE, a);
        fetch(a, 1'b0, got, cyc);
        repeat (20) @(negedge clk); // room for the next-line prefetch
        a = a + cache_pkg::addr_t'(LINE_BYTES);
        fetch(a, 1'b0, got, cyc);
        if (got !== expected_line(a)) begin
            $display("error next_line expected %h actual %h", expected_line(a), got);
            errors++;
        end
        if (cyc != 1) begin
            $display("error next_line expected 1 cycle actual %0d", cyc);
            errors++;
        end
        finish_test("next_line");

        // the branch fetch lands while the following prefetch is still in flight
        repeat (2) @(negedge clk);
        random_addr(BR_BASE, a);
        fetch(a, 1'b1, got, cyc);
        repeat (20) @(negedge clk);
        a = a + cache_pkg::addr_t'(LINE_BYTES);
        fetch(a, 1'b0, got, cyc);
        if (got !== expected_line(a)) begin
            $display("error branch_suppress expected %h actual %h", expected_line(a), got);
            errors++;
        end
        if (cyc <= 1) begin
            $display("error branch_suppress expected more than 1 cycle actual %0d", cyc);
            errors++;
        end
        finish_test("branch_suppress");

        for (int n = 0; n < N_MIXED; n++) begin
            random_addr('0, d_list[n]);
            random_addr('0, i_list[n]);
        end
        // both caches compete for the one memory port
        fork
            for (int n = 0; n < N_MIXED; n++) begin
                data_read(d_list[n], d_got);
                if (d_got !== expected_line(d_list[n])) begin
                    $display("error contention_d expected %h actual %h",
                             expected_line(d_list[n]), d_got);
                    errors++;
                end
            end
            for (int n = 0; n < N_MIXED; n++) begin
                fetch(i_list[n], 1'b0, i_got, cyc);
                if (i_got !== expected_line(i_list[n])) begin
                    $display("error contention_i expected %h actual %h",
                             expected_line(i_list[n]), i_got);
                    errors++;
                end
            end
        join
        finish_test("contention");

        $display("tests: %0d passed, %0d failed, errors: %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* fetch_subsystem.sv */
`timescale 1ns/1ps

module fetch_subsystem (
    input  logic                clk,
    input  logic                rst,
    // instruction fetch
    input  logic                i_read,
    input  cache_pkg::addr_t    i_addr,
    input  logic                branch_taken,
    output cache_pkg::line_t    i_rdata,
    output logic                i_resp,
    // data load
    input  logic                d_read,
    input  cache_pkg::addr_t    d_addr,
    output cache_pkg::line_t    d_rdata,
    output logic                d_resp,
    // memory backdoor
    input  logic                load_we,
    input  bus_pkg::mem_index_t load_index,
    input  cache_pkg::line_t    load_data
);

    // prefetcher to icache
    logic             ic_read;
    logic             ic_resp;
    cache_pkg::addr_t ic_addr;
    cache_pkg::line_t ic_rdata;

    // caches to arbiter
    logic             im_read, im_resp;
    logic             dm_read, dm_resp;
    cache_pkg::addr_t im_addr, dm_addr;
    cache_pkg::line_t im_rdata, dm_rdata;

    // arbiter to memory
    logic                mem_rd_en;
    logic                mem_rd_valid;
    bus_pkg::mem_index_t mem_rd_index;
    cache_pkg::line_t    mem_rdata;
    logic                arbiter_idle;

    next_line_prefetcher u_prefetch (
        .clk(clk), .rst(rst),
        .i_addr(i_addr), .i_read(i_read), .i_rdata(i_rdata), .i_resp(i_resp),
        .ic_rdata(ic_rdata), .ic_resp(ic_resp), .ic_addr(ic_addr), .ic_read(ic_read),
        .branch_taken(branch_taken), .arbiter_idle(arbiter_idle)
    );

    line_cache u_icache (
        .clk(clk), .rst(rst),
        .read(ic_read), .addr(ic_addr), .rdata(ic_rdata), .resp(ic_resp),
        .mem_read(im_read), .mem_addr(im_addr), .mem_rdata(im_rdata), .mem_resp(im_resp)
    );

    line_cache u_dcache (
        .clk(clk), .rst(rst),
        .read(d_read), .addr(d_addr), .rdata(d_rdata), .resp(d_resp),
        .mem_read(dm_read), .mem_addr(dm_addr), .mem_rdata(dm_rdata), .mem_resp(dm_resp)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst(rst),
        .d_mem_read(dm_read), .d_mem_addr(dm_addr),
        .d_mem_rdata(dm_rdata), .d_mem_resp(dm_resp),
        .i_mem_read(im_read), .i_mem_addr(im_addr),
        .i_mem_rdata(im_rdata), .i_mem_resp(im_resp),
        .mem_rd_en(mem_rd_en), .mem_rd_index(mem_rd_index),
        .mem_rdata(mem_rdata), .mem_rd_valid(mem_rd_valid),
        .arbiter_idle(arbiter_idle)
    );

    main_memory u_mem (
        .clk(clk), .rst(rst),
        .rd_en(mem_rd_en), .rd_index(mem_rd_index),
        .rdata(mem_rdata), .rd_valid(mem_rd_valid),
        .load_we(load_we), .load_index(load_index), .load_data(load_data)
    );

endmodule

/* main_memory.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module main_memory (
    input  logic                clk,
    input  logic                rst,
    // read port
    input  logic                rd_en,
    input  bus_pkg::mem_index_t rd_index,
    output cache_pkg::line_t    rdata,
    output logic                rd_valid,
    // backdoor fill
    input  logic                load_we,
    input  bus_pkg::mem_index_t load_index,
    input  cache_pkg::line_t    load_data
);

    cache_pkg::line_t mem       [`MEM_LINES];
    cache_pkg::line_t data_pipe [`MEM_LATENCY];
    logic [`MEM_LATENCY-1:0] valid_pipe;

    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_index] <= load_data;
        end
    end

    // array read on accept, then carried down the delay line
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_index];
        for (int i = 1; i < `MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= (valid_pipe << 1) | `MEM_LATENCY'(rd_en); // several reads may overlap
        end
    end

    assign rdata    = data_pipe[`MEM_LATENCY-1];
    assign rd_valid = valid_pipe[`MEM_LATENCY-1];

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    // data cache
    input  logic                d_mem_read,
    input  cache_pkg::addr_t    d_mem_addr,
    output cache_pkg::line_t    d_mem_rdata,
    output logic                d_mem_resp,
    // instruction cache
    input  logic                i_mem_read,
    input  cache_pkg::addr_t    i_mem_addr,
    output cache_pkg::line_t    i_mem_rdata,
    output logic                i_mem_resp,
    // main memory
    output logic                mem_rd_en,
    output bus_pkg::mem_index_t mem_rd_index,
    input  cache_pkg::line_t    mem_rdata,
    input  logic                mem_rd_valid,
    output logic                arbiter_idle
);

    localparam int OFFSET_BITS = $clog2(`LINE_BITS / 8);
    localparam int MIDX_BITS   = $bits(bus_pkg::mem_index_t);

    bus_pkg::arb_state_t state, next_state;
    bus_pkg::req_id_t    grant;
    logic                busy;

    assign busy  = (state != bus_pkg::FREE);
    assign grant = (state == bus_pkg::BUSY_D) ? bus_pkg::DATA : bus_pkg::INSTR;

    // shared return bus where only the granted side gets the resp
    assign d_mem_rdata = mem_rdata;
    assign i_mem_rdata = mem_rdata;
    assign d_mem_resp  = busy && mem_rd_valid && (grant == bus_pkg::DATA);
    assign i_mem_resp  = busy && mem_rd_valid && (grant == bus_pkg::INSTR);

    assign arbiter_idle = !busy && !d_mem_read && !i_mem_read;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bus_pkg::FREE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        mem_rd_en    = 1'b0;
        mem_rd_index = '0;
        case (state)
            bus_pkg::FREE: begin
                if (d_mem_read) begin // data first
                    next_state   = bus_pkg::BUSY_D;
                    mem_rd_en    = 1'b1;
                    mem_rd_index = d_mem_addr[OFFSET_BITS +: MIDX_BITS];
                end else if (i_mem_read) begin
                    next_state   = bus_pkg::BUSY_I;
                    mem_rd_en    = 1'b1;
                    mem_rd_index = i_mem_addr[OFFSET_BITS +: MIDX_BITS];
                end
            end
            bus_pkg::BUSY_D, bus_pkg::BUSY_I: begin
                if (mem_rd_valid) next_state = bus_pkg::FREE;
            end
            default: next_state = bus_pkg::FREE;
        endcase
    end

    // a response only goes to the cache that still waits for it
    resp_to_dcache: assert property (@(posedge clk) disable iff (rst)
        d_mem_resp |-> d_mem_read);

    resp_to_icache: assert property (@(posedge clk) disable iff (rst)
        i_mem_resp |-> i_mem_read);

    // memory must answer every grant after its fixed latency
    rd_latency: assert property (@(posedge clk) disable iff (rst)
        mem_rd_en |-> ##`MEM_LATENCY mem_rd_valid);

endmodule

/* line_cache.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module line_cache (
    input  logic             clk,
    input  logic             rst,
    // requester side
    input  logic             read,
    input  cache_pkg::addr_t addr,
    output cache_pkg::line_t rdata,
    output logic             resp,
    // memory side through the arbiter
    output logic             mem_read,
    output cache_pkg::addr_t mem_addr,
    input  cache_pkg::line_t mem_rdata,
    input  logic             mem_resp
);

    localparam int OFFSET_BITS = $clog2(`LINE_BITS / 8);
    localparam int INDEX_BITS  = $bits(cache_pkg::index_t);
    localparam int TAG_BITS    = $bits(cache_pkg::tag_t);

    cache_pkg::cache_state_t state, next_state;

    logic [`CACHE_LINES-1:0] valid;
    cache_pkg::tag_t         tags  [`CACHE_LINES];
    cache_pkg::line_t        lines [`CACHE_LINES];
    cache_pkg::line_t        rdata_q;

    cache_pkg::index_t index;
    cache_pkg::tag_t   tag;
    logic              hit;
    logic              fill;

    assign index = addr[OFFSET_BITS +: INDEX_BITS];
    assign tag   = addr[`ADDR_BITS-1 -: TAG_BITS];
    assign hit   = valid[index] && (tags[index] == tag);
    assign fill  = (state == cache_pkg::MISS_WAIT) && mem_resp;

    // miss request is the whole aligned line, held until mem_resp
    assign mem_addr = {addr[`ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign mem_read = (state == cache_pkg::MISS_WAIT);

    assign resp  = (state == cache_pkg::RESPOND);
    assign rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::LOOKUP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::LOOKUP: begin
                if (read) begin
                    next_state = hit ? cache_pkg::RESPOND : cache_pkg::MISS_WAIT;
                end
            end
            cache_pkg::MISS_WAIT: if (mem_resp) next_state = cache_pkg::RESPOND;
            cache_pkg::RESPOND:   next_state = cache_pkg::LOOKUP; // one-cycle resp pulse
            default:              next_state = cache_pkg::LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (fill) begin
            valid[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill) begin
            lines[index] <= mem_rdata;
            tags[index]  <= tag;
        end
    end

    // output line register, array read on lookup or bypass of the fill
    always_ff @(posedge clk) begin
        if (state == cache_pkg::LOOKUP && read) begin
            rdata_q <= lines[index];
        end else if (fill) begin
            rdata_q <= mem_rdata;
        end
    end

    resp_in_read: assert property (@(posedge clk) disable iff (rst)
        resp |-> read);

endmodule

/* next_line_prefetcher.sv */
`timescale 1ns/1ps
`include "fetch_consts.svh"

module next_line_prefetcher (
    input  logic             clk,
    input  logic             rst,
    // cpu fetch port
    input  cache_pkg::addr_t i_addr,
    input  logic             i_read,
    output cache_pkg::line_t i_rdata,
    output logic             i_resp,
    // instruction cache port
    input  cache_pkg::line_t ic_rdata,
    input  logic             ic_resp,
    output cache_pkg::addr_t ic_addr,
    output logic             ic_read,
    // hints
    input  logic             branch_taken,
    input  logic             arbiter_idle
);

    localparam int LINE_BYTES  = `LINE_BITS / 8;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    cache_pkg::pf_state_t state, next_state;

    logic             no_pf;     // blocks prefetch until the next non-branch fetch
    logic             br_pend;   // branch pulse seen while its fetch still waits
    logic             pf_ok;
    cache_pkg::addr_t last_line; // last line handed to the cpu
    cache_pkg::addr_t last_pf;   // last line pulled in by prefetch
    cache_pkg::addr_t pf_addr;
    cache_pkg::addr_t i_line;

    assign i_line  = {i_addr[`ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign pf_addr = last_line + cache_pkg::addr_t'(LINE_BYTES); // sequential next line

    // only prefetch into a quiet bus and never the same line twice in a row
    assign pf_ok = !no_pf && arbiter_idle && (pf_addr != last_pf);

    // the cpu always sees the cache data and i_resp decides if it counts
    assign i_rdata = ic_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            no_pf   <= 1'b1; // first line after reset is never followed
            br_pend <= 1'b0;
        end else if (state == cache_pkg::IDLE && next_state == cache_pkg::SERVE_I) begin
            no_pf   <= branch_taken || br_pend; // the pulse may have come during a prefetch
            br_pend <= 1'b0;
        end else if (branch_taken) begin
            no_pf   <= 1'b1;
            br_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_line <= '0;
            last_pf   <= '0;
        end else if (state == cache_pkg::SERVE_I && ic_resp) begin
            last_line <= i_line;
        end else if (state == cache_pkg::PREFETCH && ic_resp) begin
            last_pf   <= pf_addr;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_pkg::IDLE: begin
                if (i_read) begin
                    next_state = cache_pkg::SERVE_I; // cpu wins over prefetch
                end else if (pf_ok) begin
                    next_state = cache_pkg::PREFETCH;
                end
            end
            cache_pkg::SERVE_I:  if (ic_resp) next_state = cache_pkg::IDLE;
            cache_pkg::PREFETCH: if (ic_resp) next_state = cache_pkg::IDLE;
            default:             next_state = cache_pkg::IDLE;
        endcase
    end

    // request goes out in the same cycle the decision is made
    always_comb begin
        ic_read = 1'b0;
        ic_addr = '0;
        i_resp  = 1'b0;
        case (state)
            cache_pkg::IDLE: begin
                if (i_read) begin
                    ic_read = 1'b1;
                    ic_addr = i_addr;
                end else if (pf_ok) begin
                    ic_read = 1'b1;
                    ic_addr = pf_addr;
                end
            end
            cache_pkg::SERVE_I: begin
                ic_read = 1'b1;
                ic_addr = i_addr;
                i_resp  = ic_resp;
            end
            cache_pkg::PREFETCH: begin
                ic_read = 1'b1;
                ic_addr = pf_addr; // response stays hidden from the cpu
            end
            default: ;
        endcase
    end

    // a leaked prefetch resp would reach the cpu with no fetch outstanding
    pf_hidden: assert property (@(posedge clk) disable iff (rst)
        !i_read |-> !i_resp);

endmodule

/* bus_pkg.sv */
`include "fetch_consts.svh"

package bus_pkg;

    // who currently owns the memory port
    typedef enum logic {
        DATA  = 1'b0,
        INSTR = 1'b1
    } req_id_t;

    typedef enum logic [1:0] {
        FREE,
        BUSY_D, // data cache read in flight
        BUSY_I  // instruction cache read in flight
    } arb_state_t;

    typedef logic [$clog2(`MEM_LINES)-1:0] mem_index_t; // line number in main memory

endpackage

/* cache_pkg.sv */
`include "fetch_consts.svh"

package cache_pkg;

    // byte address and one full line
    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`LINE_BITS-1:0] line_t;

    typedef logic [$clog2(`CACHE_LINES)-1:0] index_t; // set select

    // address bits left above the set index and the byte offset
    typedef logic [`ADDR_BITS-$clog2(`CACHE_LINES)-$clog2(`LINE_BITS/8)-1:0] tag_t;

    typedef enum logic [1:0] {
        IDLE,     // nothing in flight
        SERVE_I,  // cpu fetch owns the icache port
        PREFETCH  // next line being pulled in
    } pf_state_t;

    typedef enum logic [1:0] {
        LOOKUP,
        MISS_WAIT, // line requested from memory
        RESPOND
    } cache_state_t;

endpackage

/* fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// sizes shared by the caches, the arbiter and main memory

// byte address width
`define ADDR_BITS 32

// one cache line, 32 bytes
`define LINE_BITS 256

// lines per direct-mapped cache
`define CACHE_LINES 16

// lines held in main memory
`define MEM_LINES 256

// cycles from an accepted read to rd_valid
`define MEM_LATENCY 4

`endif
